//--- Bender.yml
package:
  name: neural_layer

sources:
  - include_dirs:
      - source
    files:
      - source/float_pkg.sv
      - source/layer_pkg.sv
      - source/mac_if.sv
      - source/float_mult.sv
      - source/float_adder.sv
      - source/neuron_node.sv
      - source/layer_sequencer.sv
      - source/neural_layer_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/clock_gen.sv
      - test/layer_tb.sv

//--- source/float_adder.sv
`timescale 1ns/1ns
`default_nettype none

module floatAdder
	import floatPkg::*;
(
	input wire floatWord a,
	input wire floatWord b,
	output floatWord sum
);
	floatWord opA;
	floatWord opB;
	floatWord bigOp;
	floatWord smallOp;
	floatExponent expDiff;
	floatSignificand sigBig;
	floatSignificand sigSmall;
	floatSignificand sigAligned;
	floatSignificand sigNorm;
	logic [24:0] sigSum;
	logic [4:0] shiftAmt;
	logic signed [9:0] expOut;

	always_comb
	begin
		// zeros and subnormals collapse to +0 before the compare
		opA = (a[30:23] == '0) ? '0 : a;
		opB = (b[30:23] == '0) ? '0 : b;
		if (opA[30:0] >= opB[30:0])
		begin
			bigOp = opA;
			smallOp = opB;
		end
		else
		begin
			bigOp = opB;
			smallOp = opA;
		end
		expDiff = bigOp[30:23] - smallOp[30:23];
		sigBig = {bigOp[30:23] != '0, bigOp[22:0]};
		sigSmall = {smallOp[30:23] != '0, smallOp[22:0]};
		// bits shifted out of the smaller significand are lost since there are no guard bits
		sigAligned = sigSmall >> expDiff;
		if (bigOp[31] == smallOp[31])
			sigSum = {1'b0, sigBig} + {1'b0, sigAligned};
		else
			sigSum = {1'b0, sigBig} - {1'b0, sigAligned};
		// highest set bit wins since the loop runs upward
		shiftAmt = '0;
		for (int i = 0; i < 24; i++)
		begin
			if (sigSum[i])
				shiftAmt = 5'(23 - i);
		end
		if (sigSum[24])
		begin
			sigNorm = sigSum[24:1];
			expOut = $signed({2'b00, bigOp[30:23]}) + 10'sd1;
		end
		else
		begin
			sigNorm = sigSum[23:0] << shiftAmt;
			expOut = $signed({2'b00, bigOp[30:23]}) - $signed({5'b00000, shiftAmt});
		end
		if (sigSum == '0 || expOut <= 10'sd0)
			sum = '0;
		else if (expOut >= 10'sd255)
			sum = {bigOp[31], 8'hff, 23'b0};
		else
			sum = {bigOp[31], expOut[7:0], sigNorm[22:0]};
	end

endmodule

`default_nettype wire

//--- source/float_mult.sv
`timescale 1ns/1ns
`default_nettype none

module floatMultiplier
	import floatPkg::*;
(
	input wire floatWord x,
	input wire floatWord y,
	output floatWord z
);
	logic sign;
	floatExponent expX;
	floatExponent expY;
	floatSignificand sigX;
	floatSignificand sigY;
	floatSignificand sigNorm;
	logic [47:0] product;
	logic [9:0] expSum;
	logic [9:0] expBiased;

	always_comb
	begin
		sign = x[31] ^ y[31];
		expX = x[30:23];
		expY = y[30:23];
		sigX = {1'b1, x[22:0]};
		sigY = {1'b1, y[22:0]};
		product = sigX * sigY;
		expSum = {2'b00, expX} + {2'b00, expY};
		// product of two values in [1,2) needs at most one bit of normalization
		if (product[47])
		begin
			sigNorm = product[47:24];
			expSum = expSum + 10'd1;
		end
		else
			sigNorm = product[46:23];
		expBiased = expSum - 10'd127;
		// subnormal operands are treated as zero
		if (expX == '0 || expY == '0)
			z = {sign, 31'b0};
		else if (expSum >= 10'd382)
			z = {sign, 8'hff, 23'b0};
		else if (expSum <= 10'd127)
			z = '0;
		else
			z = {sign, expBiased[7:0], sigNorm[22:0]};
	end

endmodule

`default_nettype wire

//--- source/float_pkg.sv
`default_nettype none

`include "neural_macros.svh"

package floatPkg;

	// whole IEEE-754 single precision word
	typedef logic [`WORD_WIDTH-1:0] floatWord;

	// biased exponent field
	typedef logic [7:0] floatExponent;

	// fraction with the hidden bit in front
	typedef logic [23:0] floatSignificand;

endpackage

`default_nettype wire

//--- source/layer_pkg.sv
`default_nettype none

`include "neural_macros.svh"

package layerPkg;

	typedef logic [$clog2(`INPUT_COUNT)-1:0] inputIndex;

	typedef logic [$clog2(`NEURON_COUNT)-1:0] neuronIndex;

	typedef enum logic [2:0] {idle, waitInReqLow, finish, present, waitOutAckLow} sequencerState;

endpackage

`default_nettype wire

//--- source/layer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "neural_macros.svh"

module layerSequencer
	import floatPkg::*;
	import layerPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic inReq,
	output logic inAck,
	input wire floatWord inData,
	macBus.master bus,
	input wire floatWord results [`NEURON_COUNT],
	output logic outReq,
	input wire logic outAck,
	output floatWord outData,
	output neuronIndex outIndex
);
	sequencerState state;
	inputIndex inCount;
	neuronIndex outCount;
	logic accept;

	assign accept = (state == idle) && inReq;

	// bias load coincides with the first accepted word of a vector
	assign bus.clear = accept && (inCount == '0);
	assign bus.done = (state == finish);
	assign bus.index = inCount;

	assign outData = results[outCount];
	assign outIndex = outCount;

	always_ff @(posedge clk)
	begin
		if (accept)
			bus.activation <= inData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			inCount <= '0;
			outCount <= '0;
			inAck <= 1'b0;
			outReq <= 1'b0;
			bus.step <= 1'b0;
		end
		else
		begin
			bus.step <= 1'b0;
			case (state)
				idle:
					if (inReq)
					begin
						bus.step <= 1'b1;
						state <= waitInReqLow;
					end
				waitInReqLow:
					// ack goes up right after the step and down once the source lets go
					if (bus.step)
						inAck <= 1'b1;
					else if (inAck && !inReq)
					begin
						inAck <= 1'b0;
						if (inCount == inputIndex'(`INPUT_COUNT - 1))
						begin
							inCount <= '0;
							state <= finish;
						end
						else
						begin
							inCount <= inCount + 1'b1;
							state <= idle;
						end
					end
				finish:
				begin
					outReq <= 1'b1;
					state <= present;
				end
				present:
					if (outAck)
					begin
						outReq <= 1'b0;
						state <= waitOutAckLow;
					end
				waitOutAckLow:
					if (!outAck)
					begin
						if (outCount == neuronIndex'(`NEURON_COUNT - 1))
						begin
							outCount <= '0;
							state <= idle;
						end
						else
						begin
							outCount <= outCount + 1'b1;
							outReq <= 1'b1;
							state <= present;
						end
					end
				default:
					state <= idle;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) $rose(inAck) |-> inReq)
		else $error("inAck raised without a pending inReq");

	assert property (@(posedge clk) disable iff (rst) outReq && $past(outReq) |-> $stable(outData))
		else $error("outData changed during an output transfer");

endmodule

`default_nettype wire

//--- source/mac_if.sv
`timescale 1ns/1ns
`default_nettype none

interface macBus
	import floatPkg::*;
	import layerPkg::*;
();
	logic clear;
	logic step;
	inputIndex index;
	floatWord activation;
	logic done;

	// one sequencer drives every neuron of the layer
	modport master (output clear, output step, output index, output activation, output done);

	modport node (input clear, input step, input index, input activation, input done);

endinterface

`default_nettype wire

//--- source/neural_layer_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "neural_macros.svh"

module neuralLayerTop
	import floatPkg::*;
	import layerPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic inReq,
	output logic inAck,
	input wire floatWord inData,
	output logic outReq,
	input wire logic outAck,
	output floatWord outData,
	output neuronIndex outIndex
);
	wire floatWord results [`NEURON_COUNT];

	macBus bus ();

	layerSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.bus(bus.master),
		.results(results),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData),
		.outIndex(outIndex)
	);

	for (genvar n = 0; n < `NEURON_COUNT; n++)
	begin : gNeuron
		neuronNode #(
			.NEURON_ID(n)
		) node (
			.clk(clk),
			.rst(rst),
			.bus(bus.node),
			.result(results[n])
		);
	end

endmodule

`default_nettype wire

//--- source/neural_macros.svh
`ifndef NEURAL_MACROS_SVH
`define NEURAL_MACROS_SVH

// activations per vector
`define INPUT_COUNT 10
// neurons side by side in the layer
`define NEURON_COUNT 3
// single precision word
`define WORD_WIDTH 32

`endif

//--- source/neuron_node.sv
`timescale 1ns/1ns
`default_nettype none

`include "neural_macros.svh"

module neuronNode
	import floatPkg::*;
#(
	parameter int NEURON_ID = 0
) (
	input wire logic clk,
	input wire logic rst,
	macBus.node bus,
	output floatWord result
);
	localparam floatWord WEIGHTS [`NEURON_COUNT][`INPUT_COUNT] = '{
		'{32'hbeb27893, 32'hbee3c857, 32'h3e0911d1, 32'h3e469e22, 32'hbeed0cc6,
			32'h3d496dad, 32'hbf06e6b5, 32'h3ec0ac7f, 32'h3ea3877b, 32'h3ec4361c},
		'{32'h3e8a3d71, 32'hbe19999a, 32'h3f0ccccd, 32'hbdcccccd, 32'h3e4ccccd,
			32'hbeb33333, 32'h3d23d70a, 32'h3ee66666, 32'hbf19999a, 32'h3e3851ec},
		'{32'hbe4ccccd, 32'h3eb33333, 32'hbe8a3d71, 32'h3f000000, 32'h3dcccccd,
			32'h3e99999a, 32'hbee66666, 32'hbd4ccccd, 32'h3e19999a, 32'hbf0ccccd}
	};

	localparam floatWord BIASES [`NEURON_COUNT] = '{32'h3e068ac7, 32'hbd8f5c29, 32'h3e800000};

	floatWord weight;
	floatWord product;
	floatWord accumNext;
	floatWord accum;

	assign weight = WEIGHTS[NEURON_ID][bus.index];

	floatMultiplier mult (
		.x(bus.activation),
		.y(weight),
		.z(product)
	);

	floatAdder add (
		.a(accum),
		.b(product),
		.sum(accumNext)
	);

	// accumulation starts from the bias, then takes products in input order
	always_ff @(posedge clk)
	begin
		if (bus.clear)
			accum <= BIASES[NEURON_ID];
		else if (bus.step)
			accum <= accumNext;
	end

	// relu also maps -0 to +0
	always_ff @(posedge clk)
	begin
		if (rst)
			result <= '0;
		else if (bus.done)
			result <= accum[`WORD_WIDTH-1] ? '0 : accum;
	end

	assert property (@(posedge clk) disable iff (rst) !(bus.clear && bus.step))
		else $error("clear and step high in the same cycle");

	assert property (@(posedge clk) disable iff (rst) bus.step |-> bus.index < `INPUT_COUNT)
		else $error("step with weight index out of range");

endmodule

`default_nettype wire

//--- test/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int PERIOD = 10
) (
	output logic clk
);
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- test/layer_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "neural_macros.svh"

module layerTb
	import floatPkg::*;
	import layerPkg::*;
();
	localparam int WORDS_PER_VECTOR = `INPUT_COUNT + `NEURON_COUNT;
	localparam int MAX_VECTORS = 64;
	localparam int CYCLES_PER_RUN = 200;

	logic clk;
	logic rst;
	logic inReq;
	logic inAck;
	floatWord inData;
	logic outReq;
	logic outAck;
	floatWord outData;
	neuronIndex outIndex;

	floatWord vectorMem [MAX_VECTORS * WORDS_PER_VECTOR];
	int vectorCount;
	int errorCount;
	int testsPassed;
	int testsFailed;

	clockGen #(
		.PERIOD(10)
	) clock (
		.clk(clk)
	);

	neuralLayerTop DUT (
		.clk(clk),
		.rst(rst),
		.inReq(inReq),
		.inAck(inAck),
		.inData(inData),
		.outReq(outReq),
		.outAck(outAck),
		.outData(outData),
		.outIndex(outIndex)
	);

	// words the file leaves untouched keep a marker that depends on the address
	function automatic floatWord fillWord(input int addr);
		return 32'hdead_beef ^ addr;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore)
		begin
			testsPassed++;
			$display("test %s: pass", name);
		end
		else
		begin
			testsFailed++;
			$display("test %s: fail", name);
		end
	endtask

	task automatic randomPause(input int maxDelay);
		int cycles;
		cycles = (maxDelay > 0) ? int'($urandom % (maxDelay + 1)) : 0;
		repeat (cycles) @(posedge clk);
	endtask

	task automatic watchdog(input int cycles);
		repeat (cycles) @(posedge clk);
		$display("timeout: the DUT stopped answering a handshake within %0d cycles", cycles);
		$display("ERRORS FOUND");
		$finish;
	endtask

	task automatic resetDut(input int cycles);
		rst <= 1'b1;
		inReq <= 1'b0;
		outAck <= 1'b0;
		repeat (cycles) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
	endtask

	// one four-phase transfer on the input side
	task automatic sendWord(input floatWord word, input int maxDelay);
		randomPause(maxDelay);
		inData <= word;
		inReq <= 1'b1;
		do
			@(posedge clk);
		while (!inAck);
		randomPause(maxDelay);
		inReq <= 1'b0;
		do
			@(posedge clk);
		while (inAck);
	endtask

	task automatic receiveResult(input int n, input floatWord expected, input int maxDelay);
		do
			@(posedge clk);
		while (!outReq);
		checkValue(32'(outIndex), n, "outIndex");
		checkValue(outData, expected, $sformatf("outData of neuron %0d", n));
		randomPause(maxDelay);
		outAck <= 1'b1;
		do
			@(posedge clk);
		while (outReq);
		randomPause(maxDelay);
		outAck <= 1'b0;
	endtask

	task automatic runVector(input int v, input int maxDelay, input string name);
		int base;
		int errorsBefore;
		base = v * WORDS_PER_VECTOR;
		errorsBefore = errorCount;
		for (int i = 0; i < `INPUT_COUNT; i++)
			sendWord(vectorMem[base + i], maxDelay);
		for (int n = 0; n < `NEURON_COUNT; n++)
			receiveResult(n, vectorMem[base + `INPUT_COUNT + n], maxDelay);
		reportTest($sformatf("%s, vector %0d", name, v), errorsBefore);
	endtask

	task automatic runAllTests;
		int errorsBefore;
		int base;
		resetDut(8);
		errorsBefore = errorCount;
		checkValue(32'(inAck), 32'h0, "inAck after reset");
		checkValue(32'(outReq), 32'h0, "outReq after reset");
		reportTest("handshake lines low after reset", errorsBefore);
		for (int v = 0; v < vectorCount; v++)
			runVector(v, 0, "no delay");
		for (int v = 0; v < vectorCount; v++)
			runVector(v, 5, "random delay");
		// drop a vector halfway once its fifth word is acknowledged
		base = (vectorCount - 1) * WORDS_PER_VECTOR;
		errorsBefore = errorCount;
		for (int i = 0; i < 4; i++)
			sendWord(vectorMem[base + i], 2);
		inData <= vectorMem[base + 4];
		inReq <= 1'b1;
		do
			@(posedge clk);
		while (!inAck);
		resetDut(8);
		checkValue(32'(inAck), 32'h0, "inAck after reset in a vector");
		checkValue(32'(outReq), 32'h0, "outReq after reset in a vector");
		reportTest("handshake lines low after reset in a vector", errorsBefore);
		runVector(vectorCount - 1, 3, "full vector after reset");
	endtask

	initial
	begin
		int runCycles;
		int lastWord;
		rst = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		errorCount = 0;
		testsPassed = 0;
		testsFailed = 0;
		vectorCount = 0;
		void'($urandom(32'h0ce7_30a0));
		for (int i = 0; i < MAX_VECTORS * WORDS_PER_VECTOR; i++)
			vectorMem[i] = fillWord(i);
		$readmemh("test/layer_vectors.txt", vectorMem);
		lastWord = WORDS_PER_VECTOR - 1;
		while (vectorCount < MAX_VECTORS && vectorMem[lastWord] !== fillWord(lastWord))
		begin
			vectorCount++;
			lastWord += WORDS_PER_VECTOR;
		end
		if (vectorCount == 0)
		begin
			$display("no test vectors could be read from test/layer_vectors.txt");
			errorCount++;
		end
		else
		begin
			runCycles = (2 * vectorCount + 2) * CYCLES_PER_RUN + 20;
			fork
				watchdog(runCycles);
			join_none
			runAllTests();
		end
		$display("%0d tests passed, %0d tests failed, %0d mismatches",
			testsPassed, testsFailed, errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/layer_vectors.txt
// per vector: ten activation words in input order on the first line,
// then the expected results of neurons 0, 1 and 2 on the second line
// all zero, each neuron gives the relu of its bias
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
3e068ac7 00000000 3e800000
// 2^30 at input 3 swamps the bias
00000000 00000000 00000000 4e800000 00000000 00000000 00000000 00000000 00000000 00000000
4d469e22 00000000 4e000000
// -2^30 at input 0
ce800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
4db27893 00000000 4d4ccccd
// 1.0 at input 9
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 3f800000
3f03bdbf 3de147b0 00000000
// 1.0 at input 2
00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
3e87ce4c 3ef5c290 00000000
// 1.0 at input 3
00000000 00000000 00000000 3f800000 00000000 00000000 00000000 00000000 00000000 00000000
3ea69474 00000000 3f400000
// 1.0 at inputs 1 and 5, then 2^30 at input 7 swallows the smaller terms
00000000 3f800000 00000000 00000000 00000000 3f800000 00000000 4e800000 00000000 00000000
4dc0ac7f 4de66666 00000000
// 2^30 at input 0 first, later 1.0 at input 4 and -1.0 at input 8
4e800000 00000000 00000000 00000000 3f800000 00000000 00000000 00000000 bf800000 00000000
00000000 4d8a3d71 00000000

//--- verilog.f
+incdir+source
source/float_pkg.sv
source/layer_pkg.sv
source/mac_if.sv
source/float_mult.sv
source/float_adder.sv
source/neuron_node.sv
source/layer_sequencer.sv
source/neural_layer_top.sv
test/clock_gen.sv
test/layer_tb.sv
